// ==== src/csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD      = 14'h0;
    localparam csr_addr_t CSR_PRMD      = 14'h1;
    localparam csr_addr_t CSR_ECFG      = 14'h4;
    localparam csr_addr_t CSR_ESTAT     = 14'h5;
    localparam csr_addr_t CSR_ERA       = 14'h6;
    localparam csr_addr_t CSR_BADV      = 14'h7;
    localparam csr_addr_t CSR_EENTRY    = 14'hc;
    localparam csr_addr_t CSR_SAVE_BASE = 14'h30;
    localparam csr_addr_t CSR_TID       = 14'h40;
    localparam csr_addr_t CSR_TCFG      = 14'h41;
    localparam csr_addr_t CSR_TVAL      = 14'h42;
    localparam csr_addr_t CSR_TICLR     = 14'h44;

    localparam ecode_t    ECODE_ADE     = 6'h8;
    localparam ecode_t    ECODE_ALE     = 6'h9;
    localparam esubcode_t ESUBCODE_ADEF = 9'h0;

    // Bit 10 is reserved and reads zero
    localparam int_vec_t ECFG_LIE_WRITABLE = 13'h1bff;

    localparam word_t TIMER_IDLE    = 32'hffff_ffff;
    localparam int    TIMER_INT_BIT = 11;

    // Single-bit field positions
    localparam int CRMD_IE_BIT       = 2;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TICLR_CLR_BIT     = 0;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        word_t     mask;
        word_t     data;
    } csr_write_t;

    typedef struct packed {
        logic      ex;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
        word_t     vaddr;
    } trap_event_t;

    typedef struct packed {
        word_t crmd;
        word_t prmd;
        word_t ecfg;
        word_t estat_no_timer;
        word_t era;
        word_t badv;
        word_t eentry;
        word_t tid;
    } trap_view_t;

    typedef struct packed {
        word_t tcfg;
        word_t tval;
        logic  timer_pending;
    } timer_view_t;

    function automatic logic csr_hit(csr_write_t wr, csr_addr_t num);
        return wr.we && (wr.addr == num);
    endfunction

    // New bit where mask is set, old bit elsewhere
    function automatic word_t masked_write(word_t old_val, word_t mask, word_t data);
        return (mask & data) | (~mask & old_val);
    endfunction

endpackage

// ==== src/trap_state_regs.sv ====
`timescale 1ns/1ps

module trap_state_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  csr_pkg::csr_write_t             csr_wr,
    input  csr_pkg::trap_event_t            trap,
    input  logic                            ertn_flush,
    input  logic [7:0]                      hw_int_in,
    input  logic                            ipi_int_in,
    input  csr_pkg::word_t                  coreid_in,
    output csr_pkg::trap_view_t             trap_view,
    output csr_pkg::word_t [SAVE_COUNT-1:0] save_regs,
    output csr_pkg::word_t                  ex_entry
);
    import csr_pkg::*;

    plv_t        crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    int_vec_t    ecfg_lie;
    logic [1:0]  estat_sw;
    logic [7:0]  estat_hw;
    logic        estat_ipi;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era;
    word_t       badv;
    logic [25:0] eentry_va;
    word_t       tid;

    int_vec_t    estat_is;
    word_t       crmd_value;
    word_t       prmd_value;
    word_t       ecfg_value;
    word_t       estat_value;
    word_t       eentry_value;
    word_t       crmd_wr;
    word_t       prmd_wr;
    word_t       ecfg_wr;
    word_t       estat_wr;
    word_t       era_wr;
    word_t       eentry_wr;
    word_t       tid_wr;
    logic        addr_err;

    assign crmd_value = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd_value = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_value = {19'b0, ecfg_lie};
    // Timer bit 11 is merged in by the read combiner
    assign estat_is = {estat_ipi, 1'b0, 1'b0, estat_hw, estat_sw};
    assign estat_value = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign eentry_value = {eentry_va, 6'b0};

    assign crmd_wr = masked_write(crmd_value, csr_wr.mask, csr_wr.data);
    assign prmd_wr = masked_write(prmd_value, csr_wr.mask, csr_wr.data);
    assign ecfg_wr = masked_write(ecfg_value, csr_wr.mask, csr_wr.data);
    assign estat_wr = masked_write(estat_value, csr_wr.mask, csr_wr.data);
    assign era_wr = masked_write(era, csr_wr.mask, csr_wr.data);
    assign eentry_wr = masked_write(eentry_value, csr_wr.mask, csr_wr.data);
    assign tid_wr = masked_write(tid, csr_wr.mask, csr_wr.data);

    // CRMD: exception, then ertn, then CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (trap.ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_hit(csr_wr, CSR_CRMD)) begin
            crmd_plv  <= crmd_wr[1:0];
            crmd_ie   <= crmd_wr[CRMD_IE_BIT];
            crmd_da   <= crmd_wr[3];
            crmd_pg   <= crmd_wr[4];
            crmd_datf <= crmd_wr[6:5];
            crmd_datm <= crmd_wr[8:7];
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_hit(csr_wr, CSR_PRMD)) begin
            prmd_pplv <= prmd_wr[1:0];
            prmd_pie  <= prmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (csr_hit(csr_wr, CSR_ECFG)) begin
            ecfg_lie <= int_vec_t'(ecfg_wr) & ECFG_LIE_WRITABLE;
        end
    end

    // Software interrupt bits
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_sw <= '0;
        end else if (csr_hit(csr_wr, CSR_ESTAT)) begin
            estat_sw <= estat_wr[1:0];
        end
    end

    // Lines are sampled, so they show one cycle late
    always_ff @(posedge clk) begin
        estat_hw  <= hw_int_in;
        estat_ipi <= ipi_int_in;
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            estat_ecode    <= trap.ecode;
            estat_esubcode <= trap.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            era <= trap.pc;
        end else if (csr_hit(csr_wr, CSR_ERA)) begin
            era <= era_wr;
        end
    end

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    // Fetch errors report the pc itself
    always_ff @(posedge clk) begin
        if (trap.ex && addr_err) begin
            if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) begin
                badv <= trap.pc;
            end else begin
                badv <= trap.vaddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_hit(csr_wr, CSR_EENTRY)) begin
            eentry_va <= eentry_wr[31:6];
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < SAVE_COUNT; n++) begin
            if (csr_hit(csr_wr, csr_addr_t'(CSR_SAVE_BASE + n))) begin
                save_regs[n] <= masked_write(save_regs[n], csr_wr.mask, csr_wr.data);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= coreid_in;
        end else if (csr_hit(csr_wr, CSR_TID)) begin
            tid <= tid_wr;
        end
    end

    assign trap_view = '{
        crmd:           crmd_value,
        prmd:           prmd_value,
        ecfg:           ecfg_value,
        estat_no_timer: estat_value,
        era:            era,
        badv:           badv,
        eentry:         eentry_value,
        tid:            tid
    };

    assign ex_entry = eentry_value;

endmodule

// ==== src/timer_unit.sv ====
`timescale 1ns/1ps

module timer_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  csr_wr,
    output csr_pkg::timer_view_t timer_view
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    word_t       tcfg_value;
    word_t       tcfg_next;
    logic        tcfg_hit;
    logic        ticlr_hit;
    word_t       timer_cnt;
    logic        timer_pending;

    assign tcfg_value = {tcfg_initval, tcfg_periodic, tcfg_en};

    // TCFG as it stands after this cycle's write
    assign tcfg_next = masked_write(tcfg_value, csr_wr.mask, csr_wr.data);
    assign tcfg_hit = csr_hit(csr_wr, CSR_TCFG);
    assign ticlr_hit = csr_hit(csr_wr, CSR_TICLR)
                    && csr_wr.mask[TICLR_CLR_BIT]
                    && csr_wr.data[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_hit) begin
            tcfg_en <= tcfg_next[TCFG_EN_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_hit) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // Counts down to zero, then reloads or parks at all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (tcfg_hit && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b0};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    // Set wins over TICLR
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_pending <= 1'b1;
        end else if (ticlr_hit) begin
            timer_pending <= 1'b0;
        end
    end

    assign timer_view = '{
        tcfg:          tcfg_value,
        tval:          timer_cnt,
        timer_pending: timer_pending
    };

endmodule

// ==== src/csr_read_combine.sv ====
`timescale 1ns/1ps

module csr_read_combine #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_pkg::csr_addr_t              csr_rd_addr,
    input  csr_pkg::trap_view_t             trap_view,
    input  csr_pkg::timer_view_t            timer_view,
    input  csr_pkg::word_t [SAVE_COUNT-1:0] save_regs,
    output csr_pkg::word_t                  csr_rdata,
    output logic                            has_int
);
    import csr_pkg::*;

    word_t    estat_value;
    int_vec_t pending;
    int_vec_t enabled;

    always_comb begin
        estat_value = trap_view.estat_no_timer;
        estat_value[TIMER_INT_BIT] = timer_view.timer_pending;
    end

    assign pending = int_vec_t'(estat_value);
    assign enabled = int_vec_t'(trap_view.ecfg);

    // Any enabled pending source, gated by global IE
    assign has_int = ((pending & enabled) != '0) && trap_view.crmd[CRMD_IE_BIT];

    always_comb begin
        case (csr_rd_addr)
            CSR_CRMD:   csr_rdata = trap_view.crmd;
            CSR_PRMD:   csr_rdata = trap_view.prmd;
            CSR_ECFG:   csr_rdata = trap_view.ecfg;
            CSR_ESTAT:  csr_rdata = estat_value;
            CSR_ERA:    csr_rdata = trap_view.era;
            CSR_BADV:   csr_rdata = trap_view.badv;
            CSR_EENTRY: csr_rdata = trap_view.eentry;
            CSR_TID:    csr_rdata = trap_view.tid;
            CSR_TCFG:   csr_rdata = timer_view.tcfg;
            CSR_TVAL:   csr_rdata = timer_view.tval;
            // Write-only TICLR reads zero here too
            default:    csr_rdata = '0;
        endcase

        // SAVE scratch window
        for (int n = 0; n < SAVE_COUNT; n++) begin
            if (csr_rd_addr == csr_addr_t'(CSR_SAVE_BASE + n)) begin
                csr_rdata = save_regs[n];
            end
        end
    end

endmodule

// ==== src/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    // Instruction side
    input  csr_pkg::csr_addr_t   csr_rd_addr,
    output csr_pkg::word_t       csr_rdata,
    input  csr_pkg::csr_write_t  csr_wr,

    // Exception and interrupt side
    input  csr_pkg::trap_event_t trap,
    input  logic                 ertn_flush,
    input  logic [7:0]           hw_int_in,
    input  logic                 ipi_int_in,
    input  csr_pkg::word_t       coreid_in,
    output csr_pkg::word_t       ex_entry,
    output logic                 has_int
);
    import csr_pkg::*;

    trap_view_t                trap_view;
    timer_view_t               timer_view;
    word_t [SAVE_COUNT-1:0]    save_regs;

    trap_state_regs #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_trap_state_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .trap       (trap),
        .ertn_flush (ertn_flush),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .coreid_in  (coreid_in),
        .trap_view  (trap_view),
        .save_regs  (save_regs),
        .ex_entry   (ex_entry)
    );

    timer_unit u_timer_unit (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .timer_view (timer_view)
    );

    csr_read_combine #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_csr_read_combine (
        .csr_rd_addr (csr_rd_addr),
        .trap_view   (trap_view),
        .timer_view  (timer_view),
        .save_regs   (save_regs),
        .csr_rdata   (csr_rdata),
        .has_int     (has_int)
    );

endmodule

// ==== tests/csr_regfile_properties.sv ====
`timescale 1ns/1ps

module csr_regfile_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 has_int,
    input csr_pkg::trap_event_t trap,
    input csr_pkg::trap_view_t  trap_view
);
    import csr_pkg::*;

    // Exception entry clears IE so no interrupt follows it
    int_needs_ie: assert property (@(posedge clk) disable iff (reset)
        trap.ex |=> !has_int)
        else $error("has_int high right after exception entry cleared CRMD IE");

    ie_low_after_reset: assert property (@(posedge clk)
        reset |=> !trap_view.crmd[CRMD_IE_BIT])
        else $error("CRMD IE set one cycle after reset");

    // Exception entry drops to kernel level
    trap_clears_plv: assert property (@(posedge clk) disable iff (reset)
        trap.ex |=> trap_view.crmd[1:0] == 2'b0)
        else $error("CRMD PLV not zero after exception entry");

endmodule

bind csr_regfile csr_regfile_properties u_props (
    .clk       (clk),
    .reset     (reset),
    .has_int   (has_int),
    .trap      (trap),
    .trap_view (trap_view)
);

// ==== tests/tb_csr_regfile.sv ====
`timescale 1ns/1ps

module tb_csr_regfile;
    import csr_pkg::*;

    localparam int NUM_CYCLES = 4000;

    logic        clk = 1'b0;
    logic        reset;
    csr_addr_t   csr_rd_addr;
    csr_write_t  csr_wr;
    trap_event_t trap;
    logic        ertn_flush;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    word_t       coreid_in;
    word_t       csr_rdata;
    word_t       ex_entry;
    logic        has_int;

    int          seed = 7458;
    int          errors = 0;
    csr_addr_t   addr_list [16];

    // Reference model, X marks bits with no known value
    logic [8:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [12:0] m_ecfg;
    logic [1:0]  m_sw;
    logic [8:0]  m_lines;
    logic [14:0] m_cause;
    word_t       m_era;
    word_t       m_badv;
    word_t       m_eentry;
    word_t       m_tid;
    word_t       m_tcfg;
    word_t       m_cnt;
    word_t       m_save [4];
    logic        m_pend;

    csr_regfile #(.SAVE_COUNT(4)) uut (.*);

    always #10 clk = ~clk;

    function automatic word_t expect_read(csr_addr_t a);
        word_t v;
        case (a)
            CSR_CRMD:   v = {23'b0, m_crmd};
            CSR_PRMD:   v = {29'b0, m_prmd};
            CSR_ECFG:   v = {19'b0, m_ecfg};
            CSR_ESTAT:  v = {1'b0, m_cause, 3'b0, m_lines[8], m_pend, 1'b0, m_lines[7:0], m_sw};
            CSR_ERA:    v = m_era;
            CSR_BADV:   v = m_badv;
            CSR_EENTRY: v = m_eentry;
            CSR_TID:    v = m_tid;
            CSR_TCFG:   v = m_tcfg;
            CSR_TVAL:   v = m_cnt;
            default:    v = '0;
        endcase
        for (int n = 0; n < 4; n++) begin
            if (a == csr_addr_t'(CSR_SAVE_BASE + n)) begin
                v = m_save[n];
            end
        end
        return v;
    endfunction

    task automatic drive_random();
        word_t r;
        word_t x;
        r = $random(seed);
        x = $random(seed);
        csr_wr.we = r[0] | r[1];
        csr_wr.addr = addr_list[x[3:0]];
        csr_wr.mask = (r[3:2] == 2'b0) ? '1 : $random(seed);
        csr_wr.data = $random(seed);
        // Full-mask TCFG writes with a short InitVal
        if (csr_wr.addr == CSR_TCFG) begin
            csr_wr.mask = '1;
            csr_wr.data[31:7] = '0;
        end
        trap.ex = (r[7:4] == 4'b0);
        trap.ecode = (r[9:8] == 2'd0) ? ECODE_ADE : (r[9:8] == 2'd1) ? ECODE_ALE : x[9:4];
        trap.esubcode = r[10] ? ESUBCODE_ADEF : x[18:10];
        trap.pc = $random(seed);
        trap.vaddr = $random(seed);
        ertn_flush = (r[14:12] == 3'b0);
        if (r[17:15] == 3'b0) begin
            hw_int_in = x[26:19];
        end
        if (r[20:18] == 3'b0) begin
            ipi_int_in = r[21];
        end
        csr_rd_addr = addr_list[x[31:28]];
    endtask

    task automatic model_step();
        word_t m;
        word_t d;
        word_t t;
        word_t cnt_old;
        logic  wr;
        m = csr_wr.mask;
        d = csr_wr.data;
        wr = csr_wr.we;
        cnt_old = m_cnt;
        if (cnt_old == '0) begin
            m_pend = 1'b1;
        end else if (wr && csr_wr.addr == CSR_TICLR && m[0] && d[0]) begin
            m_pend = 1'b0;
        end
        if (wr && csr_wr.addr == CSR_TCFG && d[0]) begin
            m_cnt = {d[31:2], 2'b0};
        end else if (m_tcfg[0] && cnt_old != '1) begin
            m_cnt = (cnt_old == '0 && m_tcfg[1]) ? {m_tcfg[31:2], 2'b0} : cnt_old - 32'd1;
        end
        if (wr && csr_wr.addr == CSR_TCFG) begin
            m_tcfg = d;
        end
        if (trap.ex) begin
            m_prmd = m_crmd[2:0];
            m_crmd[2:0] = '0;
            m_cause = {trap.esubcode, trap.ecode};
            m_era = trap.pc;
            if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) begin
                m_badv = trap.pc;
            end else if (trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE) begin
                m_badv = trap.vaddr;
            end
        end else begin
            if (ertn_flush) begin
                m_crmd[2:0] = m_prmd;
            end else if (wr && csr_wr.addr == CSR_CRMD) begin
                t = (m & d) | (~m & {23'b0, m_crmd});
                m_crmd = t[8:0];
            end
            if (wr && csr_wr.addr == CSR_PRMD) begin
                t = (m & d) | (~m & {29'b0, m_prmd});
                m_prmd = t[2:0];
            end
            if (wr && csr_wr.addr == CSR_ERA) begin
                m_era = (m & d) | (~m & m_era);
            end
        end
        if (wr && csr_wr.addr == CSR_ECFG) begin
            t = (m & d) | (~m & {19'b0, m_ecfg});
            m_ecfg = t[12:0] & 13'h1bff;
        end
        if (wr && csr_wr.addr == CSR_ESTAT) begin
            m_sw = (m[1:0] & d[1:0]) | (~m[1:0] & m_sw);
        end
        if (wr && csr_wr.addr == CSR_EENTRY) begin
            t = (m & d) | (~m & m_eentry);
            m_eentry = {t[31:6], 6'b0};
        end
        if (wr && csr_wr.addr == CSR_TID) begin
            m_tid = (m & d) | (~m & m_tid);
        end
        for (int n = 0; n < 4; n++) begin
            if (wr && csr_wr.addr == csr_addr_t'(CSR_SAVE_BASE + n)) begin
                m_save[n] = (m & d) | (~m & m_save[n]);
            end
        end
        m_lines = {ipi_int_in, hw_int_in};
    endtask

    task automatic check_outputs();
        word_t exp;
        logic  exp_int;
        exp = expect_read(csr_rd_addr);
        if (!$isunknown(exp)) begin
            assert (csr_rdata === exp) else begin
                errors++;
                $display("CHECK FAILED at %0t: csr 0x%0h read 0x%08h, expected 0x%08h",
                         $time, csr_rd_addr, csr_rdata, exp);
            end
        end
        exp_int = ((({m_lines[8], m_pend, 1'b0, m_lines[7:0], m_sw} & m_ecfg) != '0) && m_crmd[2]);
        if (!$isunknown(exp_int)) begin
            assert (has_int === exp_int) else begin
                errors++;
                $display("CHECK FAILED at %0t: has_int is %b, expected %b", $time, has_int, exp_int);
            end
        end
        if (!$isunknown(m_eentry)) begin
            assert (ex_entry === m_eentry) else begin
                errors++;
                $display("CHECK FAILED at %0t: ex_entry 0x%08h, expected 0x%08h",
                         $time, ex_entry, m_eentry);
            end
        end
    endtask

    initial begin
        addr_list = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                      CSR_SAVE_BASE, 14'h31, 14'h32, 14'h33, CSR_TID, CSR_TCFG, CSR_TVAL,
                      CSR_TICLR, 14'h3ff};
        reset = 1'b1;
        csr_rd_addr = CSR_CRMD;
        csr_wr = '0;
        trap = '0;
        ertn_flush = 1'b0;
        hw_int_in = '0;
        ipi_int_in = 1'b0;
        coreid_in = 32'h0000_0003;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        m_crmd = 9'b0_0000_1000;
        m_prmd = 'x;
        m_ecfg = '0;
        m_sw = '0;
        m_lines = '0;
        m_cause = 'x;
        m_era = 'x;
        m_badv = 'x;
        m_eentry = 'x;
        m_tid = coreid_in;
        m_tcfg = {30'bx, 1'bx, 1'b0};
        m_cnt = '1;
        m_save = '{default: 'x};
        m_pend = 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_random();
            @(posedge clk);
            model_step();
            @(negedge clk);
            check_outputs();
        end
        $display("Run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_CYCLES * 20 + 2000);
        $display("Simulation did not finish in the expected time and was stopped");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
src/csr_pkg.sv
src/trap_state_regs.sv
src/timer_unit.sv
src/csr_read_combine.sv
src/csr_regfile.sv
tests/csr_regfile_properties.sv
tests/tb_csr_regfile.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_csr_regfile -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1
